//--- Bender.yml
package:
  name: uart_string_handle

sources:
  - files:
      - hw/uart_pkg.sv
      - hw/string_pkg.sv
      - hw/uart_tx.sv
      - hw/uart_rx.sv
      - hw/string_framer.sv
      - hw/string_deframer.sv
      - hw/uart_string_handle.sv
  - target: test
    files:
      - testbench/uart_string_handle_asserts.sv
      - testbench/tb_uart_string_handle.sv

//--- hw/string_deframer.sv
// String deframer
// Watches received bytes for "&&", gathers the payload up to the closing
// "&&" and reports the message, or an error when it ran past MAX_CHARS
`timescale 1ns/100ps

module string_deframer (
	input  logic                 sys_clk,
	input  logic                 sys_rst_n,
	input  uart_pkg::uart_byte_t byte_data,
	input  logic                 byte_vld,
	output string_pkg::str_msg_t rx_msg,
	output logic                 rx_busy,
	output logic                 rx_done,
	output logic                 rx_error
);
	import uart_pkg::*;
	import string_pkg::*;

	typedef enum logic [1:0] {
		DF_IDLE,
		DF_MARK1,
		DF_CONTENT,
		DF_PEND
	} df_state_t;

	df_state_t state;
	str_data_t wbuf;
	str_len_t  wlen;
	logic      overflow;
	logic      is_mark;
	logic      take_one;
	logic      take_two;
	logic      room_one;
	logic      room_two;

	assign is_mark  = (byte_data == FRAME_MARK);
	assign room_one = (wlen < str_len_t'(MAX_CHARS));
	assign room_two = (wlen <= str_len_t'(MAX_CHARS - 2));

	// A plain character in content, or a lone "&" plus the character after it
	assign take_one = byte_vld && !is_mark && (state == DF_CONTENT);
	assign take_two = byte_vld && !is_mark && (state == DF_PEND);

	assign rx_busy = (state != DF_IDLE);

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state    <= DF_IDLE;
			wlen     <= '0;
			overflow <= 1'b0;
			rx_done  <= 1'b0;
			rx_error <= 1'b0;
			rx_msg   <= '0;
		end else begin
			rx_done  <= 1'b0;
			rx_error <= 1'b0;
			if (byte_vld) begin
				case (state)
					DF_IDLE: begin
						if (is_mark) begin
							state <= DF_MARK1;
						end
					end
					DF_MARK1: begin
						wlen     <= '0;
						overflow <= 1'b0;
						state    <= is_mark ? DF_CONTENT : DF_IDLE;
					end
					DF_CONTENT: begin
						if (is_mark) begin
							state <= DF_PEND;
						end else if (room_one) begin
							wlen <= wlen + 1'b1;
						end else begin
							overflow <= 1'b1;
						end
					end
					DF_PEND: begin
						if (is_mark) begin
							// Closing marker, publish only a message that fit
							state    <= DF_IDLE;
							rx_done  <= !overflow;
							rx_error <= overflow;
							if (!overflow) begin
								rx_msg.data   <= wbuf;
								rx_msg.length <= wlen;
							end
						end else begin
							state <= DF_CONTENT;
							if (room_two) begin
								wlen <= wlen + str_len_t'(2);
							end else begin
								overflow <= 1'b1;
							end
						end
					end
					default: state <= DF_IDLE;
				endcase
			end
		end
	end

	// Working buffer, characters above wlen are left over from older frames
	always_ff @(posedge sys_clk) begin
		if (take_one && room_one) begin
			wbuf[int'(wlen)*DATA_BITS +: DATA_BITS] <= byte_data;
		end
		if (take_two && room_two) begin
			wbuf[int'(wlen)*DATA_BITS +: DATA_BITS]     <= FRAME_MARK;
			wbuf[(int'(wlen)+1)*DATA_BITS +: DATA_BITS] <= byte_data;
		end
	end

endmodule

//--- hw/string_framer.sv
// String framer
// Turns a host message into the byte sequence "&&", payload, "&&" and hands
// the bytes one at a time to the UART transmitter
`timescale 1ns/100ps

module string_framer (
	input  logic                 sys_clk,
	input  logic                 sys_rst_n,
	input  string_pkg::str_msg_t tx_msg,
	input  logic                 tx_req,
	output logic                 tx_busy,
	output logic                 tx_done,
	output uart_pkg::uart_byte_t byte_data,
	output logic                 byte_req,
	input  logic                 byte_done
);
	import uart_pkg::*;
	import string_pkg::*;

	typedef enum logic [6:0] {
		FR_IDLE    = 7'b000_0001,
		FR_SIGN1   = 7'b000_0010,
		FR_SIGN2   = 7'b000_0100,
		FR_CONTENT = 7'b000_1000,
		FR_SIGN3   = 7'b001_0000,
		FR_SIGN4   = 7'b010_0000,
		FR_FINISH  = 7'b100_0000
	} fr_state_t;

	fr_state_t  state;
	str_data_t  data_q;
	str_len_t   len_q;
	str_len_t   char_idx;
	logic       accept;
	logic       load_byte;
	logic       at_end;
	uart_byte_t next_byte;

	function automatic uart_byte_t char_at(input str_data_t data, input str_len_t idx);
		return data[int'(idx)*DATA_BITS +: DATA_BITS];
	endfunction

	// FINISH is not busy, so a request there starts the next frame at once
	assign accept  = tx_req && (state == FR_IDLE || state == FR_FINISH);
	assign tx_busy = !(state == FR_IDLE || state == FR_FINISH);
	assign tx_done = (state == FR_FINISH);

	assign at_end    = (char_idx == len_q);
	assign load_byte = accept || (byte_done && state inside {FR_SIGN1, FR_SIGN2,
		FR_CONTENT, FR_SIGN3});

	always_comb begin
		next_byte = FRAME_MARK;
		if ((state == FR_SIGN2 || state == FR_CONTENT) && !at_end) begin
			next_byte = char_at(data_q, char_idx);
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state    <= FR_IDLE;
			byte_req <= 1'b0;
			char_idx <= '0;
		end else begin
			byte_req <= load_byte;
			if (accept) begin
				state    <= FR_SIGN1;
				char_idx <= '0;
			end else if (state == FR_FINISH) begin
				state <= FR_IDLE;
			end else if (byte_done) begin
				case (state)
					FR_SIGN1: state <= FR_SIGN2;
					FR_SIGN2, FR_CONTENT: begin
						// An empty message skips the payload entirely
						if (at_end) begin
							state <= FR_SIGN3;
						end else begin
							state    <= FR_CONTENT;
							char_idx <= char_idx + 1'b1;
						end
					end
					FR_SIGN3: state <= FR_SIGN4;
					FR_SIGN4: state <= FR_FINISH;
					default:  state <= FR_IDLE;
				endcase
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		if (accept) begin
			data_q <= tx_msg.data;
			len_q  <= (tx_msg.length > str_len_t'(MAX_CHARS)) ? str_len_t'(MAX_CHARS)
				: tx_msg.length;
		end
		if (load_byte) begin
			byte_data <= next_byte;
		end
	end

endmodule

//--- hw/string_pkg.sv
// String layer definitions
// Message layout, frame marker and size limits for framer and deframer
package string_pkg;

	// Longest payload a frame may carry
	localparam int unsigned MAX_CHARS = 128;

	// Bits taken by one stored character
	localparam int unsigned CHAR_BITS = $bits(uart_pkg::uart_byte_t);

	// Frames open and close with two of these in a row ("&")
	localparam uart_pkg::uart_byte_t FRAME_MARK = 8'h26;

	// Character count, wide enough to hold MAX_CHARS itself
	typedef logic [$clog2(MAX_CHARS+1)-1:0] str_len_t;

	// Character i sits in bits 8i+7 down to 8i, character 0 goes out first
	typedef logic [MAX_CHARS*CHAR_BITS-1:0] str_data_t;

	typedef struct packed {
		str_data_t data;
		str_len_t  length;
	} str_msg_t;

endpackage

//--- hw/uart_pkg.sv
// UART bit-level definitions
// Character type and line levels shared by the serializer and the sampler
package uart_pkg;

	// Data bits per character, no parity on this link
	localparam int unsigned DATA_BITS = 8;

	// One character as it travels on the line, LSB sent first
	typedef logic [DATA_BITS-1:0] uart_byte_t;

	// The line rests high between characters and a start bit pulls it low
	localparam logic LINE_IDLE   = 1'b1;
	localparam logic START_LEVEL = 1'b0;

endpackage

//--- hw/uart_rx.sv
// UART receiver
// Synchronizes the serial input, finds the start edge and samples every
// bit at mid-bit, strobing byte_vld when the stop bit reads high
`timescale 1ns/100ps

module uart_rx #(
	parameter int unsigned CLK_FREQ_HZ = 50_000_000,
	parameter int unsigned BAUD_RATE   = 115_200
) (
	input  logic                 sys_clk,
	input  logic                 sys_rst_n,
	input  logic                 rxd,
	output uart_pkg::uart_byte_t byte_data,
	output logic                 byte_vld
);
	import uart_pkg::*;

	localparam int unsigned CLKS_PER_BIT = CLK_FREQ_HZ / BAUD_RATE;
	localparam int unsigned BAUD_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
	localparam int unsigned HALF_BIT = (CLKS_PER_BIT > 1) ? CLKS_PER_BIT / 2 : 1;
	localparam int unsigned BIT_W = $clog2(DATA_BITS);

	typedef enum logic [1:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP
	} rx_state_t;

	rx_state_t         state;
	logic              rxd_meta;
	logic              rxd_sync;
	logic              rxd_prev;
	logic              start_edge;
	logic              bit_end;
	logic [BAUD_W-1:0] baud_cnt;
	logic [BIT_W-1:0]  bit_cnt;
	uart_byte_t        data_sr;

	assign start_edge = (rxd_prev == LINE_IDLE) && (rxd_sync == START_LEVEL);
	assign bit_end    = (baud_cnt == BAUD_W'(CLKS_PER_BIT - 1));
	assign byte_data  = data_sr;

	// Two flops against metastability, the third keeps the previous level
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rxd_meta <= LINE_IDLE;
			rxd_sync <= LINE_IDLE;
			rxd_prev <= LINE_IDLE;
		end else begin
			rxd_meta <= rxd;
			rxd_sync <= rxd_meta;
			rxd_prev <= rxd_sync;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state    <= RX_IDLE;
			baud_cnt <= '0;
			bit_cnt  <= '0;
			byte_vld <= 1'b0;
		end else begin
			byte_vld <= 1'b0;
			case (state)
				RX_IDLE: begin
					baud_cnt <= '0;
					if (start_edge) begin
						state <= RX_START;
					end
				end
				RX_START: begin
					// A start bit that is high again at mid-bit was only a glitch
					if (baud_cnt == BAUD_W'(HALF_BIT - 1)) begin
						baud_cnt <= '0;
						bit_cnt  <= '0;
						state    <= (rxd_sync == START_LEVEL) ? RX_DATA : RX_IDLE;
					end else begin
						baud_cnt <= baud_cnt + 1'b1;
					end
				end
				RX_DATA: begin
					if (bit_end) begin
						baud_cnt <= '0;
						if (bit_cnt == BIT_W'(DATA_BITS - 1)) begin
							state <= RX_STOP;
						end else begin
							bit_cnt <= bit_cnt + 1'b1;
						end
					end else begin
						baud_cnt <= baud_cnt + 1'b1;
					end
				end
				RX_STOP: begin
					if (bit_end) begin
						baud_cnt <= '0;
						byte_vld <= (rxd_sync == LINE_IDLE);
						state    <= RX_IDLE;
					end else begin
						baud_cnt <= baud_cnt + 1'b1;
					end
				end
				default: state <= RX_IDLE;
			endcase
		end
	end

	// Bits arrive LSB first, so they enter at the top and move down
	always_ff @(posedge sys_clk) begin
		if (state == RX_DATA && bit_end) begin
			data_sr <= {rxd_sync, data_sr[DATA_BITS-1:1]};
		end
	end

endmodule

//--- hw/uart_string_handle.sv
// UART string transceiver, top level
// Connects the framer to the UART transmitter and the UART receiver to
// the deframer; messages travel as "&&" payload "&&"
`timescale 1ns/100ps

module uart_string_handle #(
	parameter int unsigned CLK_FREQ_HZ = 50_000_000,
	parameter int unsigned BAUD_RATE   = 115_200
) (
	input  logic                 sys_clk,
	input  logic                 sys_rst_n,
	input  string_pkg::str_msg_t tx_msg,
	input  logic                 tx_req,
	output logic                 tx_busy,
	output logic                 tx_done,
	output string_pkg::str_msg_t rx_msg,
	output logic                 rx_busy,
	output logic                 rx_done,
	output logic                 rx_error,
	input  logic                 uart_rx_port,
	output logic                 uart_tx_port
);
	import uart_pkg::*;

	uart_byte_t tx_byte;
	logic       tx_byte_req;
	logic       tx_byte_done;
	uart_byte_t rx_byte;
	logic       rx_byte_vld;

	string_framer string_framer_i (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.tx_msg    (tx_msg),
		.tx_req    (tx_req),
		.tx_busy   (tx_busy),
		.tx_done   (tx_done),
		.byte_data (tx_byte),
		.byte_req  (tx_byte_req),
		.byte_done (tx_byte_done)
	);

	// Two stop bits on the way out give the far receiver some slack
	uart_tx #(
		.CLK_FREQ_HZ (CLK_FREQ_HZ),
		.BAUD_RATE   (BAUD_RATE),
		.STOP_BITS   (2)
	) uart_tx_i (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.byte_data (tx_byte),
		.byte_req  (tx_byte_req),
		.txd       (uart_tx_port),
		.byte_done (tx_byte_done)
	);

	uart_rx #(
		.CLK_FREQ_HZ (CLK_FREQ_HZ),
		.BAUD_RATE   (BAUD_RATE)
	) uart_rx_i (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.rxd       (uart_rx_port),
		.byte_data (rx_byte),
		.byte_vld  (rx_byte_vld)
	);

	string_deframer string_deframer_i (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.byte_data (rx_byte),
		.byte_vld  (rx_byte_vld),
		.rx_msg    (rx_msg),
		.rx_busy   (rx_busy),
		.rx_done   (rx_done),
		.rx_error  (rx_error)
	);

endmodule

//--- hw/uart_tx.sv
// UART transmitter
// Sends one byte per request as start bit, data bits LSB first and
// STOP_BITS stop bits, then pulses byte_done in the last stop-bit cycle
`timescale 1ns/100ps

module uart_tx #(
	parameter int unsigned CLK_FREQ_HZ = 50_000_000,
	parameter int unsigned BAUD_RATE   = 115_200,
	parameter int unsigned STOP_BITS   = 1
) (
	input  logic                 sys_clk,
	input  logic                 sys_rst_n,
	input  uart_pkg::uart_byte_t byte_data,
	input  logic                 byte_req,
	output logic                 txd,
	output logic                 byte_done
);
	import uart_pkg::*;

	localparam int unsigned CLKS_PER_BIT = CLK_FREQ_HZ / BAUD_RATE;
	localparam int unsigned BAUD_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
	localparam int unsigned FRAME_BITS = 1 + DATA_BITS + STOP_BITS;
	localparam int unsigned BIT_W = $clog2(FRAME_BITS);

	logic                           busy;
	logic [BAUD_W-1:0]              baud_cnt;
	logic [BIT_W-1:0]               bit_cnt;
	logic [DATA_BITS+STOP_BITS-1:0] shift_reg;
	logic                           bit_end;
	logic                           last_bit;

	assign bit_end  = (baud_cnt == BAUD_W'(CLKS_PER_BIT - 1));
	assign last_bit = (bit_cnt == BIT_W'(FRAME_BITS - 1));

	assign byte_done = busy && last_bit && bit_end;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			busy     <= 1'b0;
			txd      <= LINE_IDLE;
			baud_cnt <= '0;
			bit_cnt  <= '0;
		end else if (!busy) begin
			// The start bit goes on the line one cycle after the request
			if (byte_req) begin
				busy     <= 1'b1;
				txd      <= START_LEVEL;
				baud_cnt <= '0;
				bit_cnt  <= '0;
			end
		end else if (bit_end) begin
			baud_cnt <= '0;
			if (last_bit) begin
				busy <= 1'b0;
				txd  <= LINE_IDLE;
			end else begin
				bit_cnt <= bit_cnt + 1'b1;
				txd     <= shift_reg[0];
			end
		end else begin
			baud_cnt <= baud_cnt + 1'b1;
		end
	end

	// Data and stop bits wait here and move down one place per bit time
	always_ff @(posedge sys_clk) begin
		if (!busy && byte_req) begin
			shift_reg <= {{STOP_BITS{LINE_IDLE}}, byte_data};
		end else if (busy && bit_end && !last_bit) begin
			shift_reg <= shift_reg >> 1;
		end
	end

endmodule

//--- testbench/tb_uart_string_handle.sv
// Testbench for the UART string transceiver
// Runs a table of loopback and injected frames, decodes the transmit line
// on its own and checks received messages, transmitted bytes and strobes
`timescale 1ns/100ps

module tb_uart_string_handle;
	import uart_pkg::*;
	import string_pkg::*;

	localparam int unsigned CLK_FREQ_HZ  = 50_000_000;
	localparam int unsigned BAUD_RATE    = 5_000_000;
	localparam int unsigned CLKS_PER_BIT = CLK_FREQ_HZ / BAUD_RATE;
	localparam int          NUM_CASES    = 9;
	localparam int          TX_TIMEOUT   = 20000;
	localparam int          RX_TIMEOUT   = 3000;

	typedef struct packed {
		logic       inject;
		str_msg_t   msg;
		logic [7:0] noise;
		logic [7:0] extra;
		logic       expect_err;
	} case_t;

	logic        sys_clk;
	logic        sys_rst_n;
	str_msg_t    tx_msg;
	logic        tx_req;
	logic        tx_busy;
	logic        tx_done;
	str_msg_t    rx_msg;
	logic        rx_busy;
	logic        rx_done;
	logic        rx_error;
	logic        uart_rx_port;
	logic        uart_tx_port;
	logic        loopback_sel;
	logic        inj_line;
	case_t       cases [NUM_CASES];
	uart_byte_t  mon_q [$];
	int          done_cnt;
	int          err_cnt;
	int          errors;
	logic [31:0] rng_state;

	uart_string_handle #(
		.CLK_FREQ_HZ (CLK_FREQ_HZ),
		.BAUD_RATE   (BAUD_RATE)
	) uart_string_handle_i (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.tx_msg       (tx_msg),
		.tx_req       (tx_req),
		.tx_busy      (tx_busy),
		.tx_done      (tx_done),
		.rx_msg       (rx_msg),
		.rx_busy      (rx_busy),
		.rx_done      (rx_done),
		.rx_error     (rx_error),
		.uart_rx_port (uart_rx_port),
		.uart_tx_port (uart_tx_port)
	);

	// The receiver hears either our own transmitter or the serial driver
	assign uart_rx_port = loopback_sel ? uart_tx_port : inj_line;

	always #10 sys_clk = ~sys_clk;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Draws the next payload character, which is never the frame marker
	function automatic uart_byte_t random_char();
		uart_byte_t c;
		rng_state = xorshift32(rng_state);
		c = rng_state[7:0];
		if (c == FRAME_MARK) begin
			c = c ^ 8'h01;
		end
		return c;
	endfunction

	function automatic int random_len();
		rng_state = xorshift32(rng_state);
		return 1 + int'(rng_state % 127);
	endfunction

	function automatic uart_byte_t char_of(input str_msg_t m, input int idx);
		return m.data[idx*DATA_BITS +: DATA_BITS];
	endfunction

	function automatic str_msg_t text_msg(input string s);
		str_msg_t m;
		int       i;
		m = '0;
		m.length = str_len_t'(s.len());
		for (i = 0; i < s.len(); i++) begin
			m.data[i*DATA_BITS +: DATA_BITS] = s[i];
		end
		return m;
	endfunction

	function automatic str_msg_t random_msg(input int len);
		str_msg_t m;
		int       i;
		m = '0;
		m.length = str_len_t'(len);
		for (i = 0; i < len; i++) begin
			m.data[i*DATA_BITS +: DATA_BITS] = random_char();
		end
		return m;
	endfunction

	// Byte k of the line image "&&", payload, "&&"
	function automatic uart_byte_t line_byte(input str_msg_t m, input int k);
		if (k < 2 || k >= int'(m.length) + 2) begin
			return FRAME_MARK;
		end
		return char_of(m, k - 2);
	endfunction

	function automatic case_t make_case(input logic inject, input str_msg_t msg,
		input int noise, input int extra, input logic expect_err);
		case_t c;
		c.inject     = inject;
		c.msg        = msg;
		c.noise      = 8'(noise);
		c.extra      = 8'(extra);
		c.expect_err = expect_err;
		return c;
	endfunction

	task automatic build_table();
		cases[0] = make_case(1'b0, text_msg(""), 0, 0, 1'b0);
		cases[1] = make_case(1'b0, text_msg("A"), 0, 0, 1'b0);
		cases[2] = make_case(1'b0, text_msg("a&b&c&d"), 0, 0, 1'b0);
		cases[3] = make_case(1'b0, random_msg(random_len()), 0, 0, 1'b0);
		cases[4] = make_case(1'b0, random_msg(random_len()), 0, 0, 1'b0);
		cases[5] = make_case(1'b0, random_msg(MAX_CHARS), 0, 0, 1'b0);
		cases[6] = make_case(1'b1, random_msg(20), 5, 0, 1'b0);
		// 128 characters plus 2 more run past the receive buffer
		cases[7] = make_case(1'b1, random_msg(MAX_CHARS), 0, 2, 1'b1);
		cases[8] = make_case(1'b1, text_msg("hi"), 0, 0, 1'b0);
	endtask

	task automatic report_mismatch(input string what);
		$display("FAILED at %0t ns: %s", $time, what);
		errors++;
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			report_mismatch($sformatf("%s is %b, expected %b", what, got, exp));
		end
	endtask

	task automatic check_byte(input uart_byte_t got, input uart_byte_t exp, input string what);
		if (got !== exp) begin
			report_mismatch($sformatf("%s is 8'h%02h, expected 8'h%02h", what, got, exp));
		end
	endtask

	task automatic check_msg(input str_msg_t got, input str_msg_t exp, input string what);
		int i;
		if (got.length !== exp.length) begin
			report_mismatch($sformatf("%s length is %0d, expected %0d", what,
				got.length, exp.length));
		end else begin
			for (i = 0; i < int'(exp.length); i++) begin
				if (char_of(got, i) !== char_of(exp, i)) begin
					report_mismatch($sformatf("%s char %0d is 8'h%02h, expected 8'h%02h",
						what, i, char_of(got, i), char_of(exp, i)));
					break;
				end
			end
		end
	endtask

	// Sends one character on the injected line with a single stop bit
	task automatic send_byte(input uart_byte_t b);
		int i;
		inj_line = START_LEVEL;
		repeat (CLKS_PER_BIT) @(negedge sys_clk);
		for (i = 0; i < DATA_BITS; i++) begin
			inj_line = b[i];
			repeat (CLKS_PER_BIT) @(negedge sys_clk);
		end
		inj_line = LINE_IDLE;
		repeat (CLKS_PER_BIT) @(negedge sys_clk);
	endtask

	task automatic inject_frame(input case_t c);
		int i;
		for (i = 0; i < int'(c.noise); i++) begin
			send_byte(random_char());
		end
		// A lone marker followed by another character must not open a frame
		if (c.noise != 0) begin
			send_byte(FRAME_MARK);
			send_byte(8'h78);
		end
		send_byte(FRAME_MARK);
		send_byte(FRAME_MARK);
		for (i = 0; i < int'(c.msg.length); i++) begin
			send_byte(char_of(c.msg, i));
		end
		for (i = 0; i < int'(c.extra); i++) begin
			send_byte(random_char());
		end
		send_byte(FRAME_MARK);
		send_byte(FRAME_MARK);
	endtask

	task automatic wait_tx_done(output logic ok);
		int n;
		ok = 1'b0;
		for (n = 0; n < TX_TIMEOUT && !ok; n++) begin
			@(negedge sys_clk);
			if (tx_done === 1'b1) begin
				ok = 1'b1;
			end
		end
		if (!ok) begin
			$display("Timeout: tx_done did not pulse within %0d cycles", TX_TIMEOUT);
		end
	endtask

	task automatic wait_rx_result(input int done0, input int err0, output logic ok);
		int n;
		ok = (done_cnt + err_cnt) > (done0 + err0);
		for (n = 0; n < RX_TIMEOUT && !ok; n++) begin
			@(negedge sys_clk);
			ok = (done_cnt + err_cnt) > (done0 + err0);
		end
		if (!ok) begin
			$display("Timeout: no rx_done or rx_error within %0d cycles", RX_TIMEOUT);
		end
	endtask

	// Independent decoder of the transmit line that samples near each mid-bit
	always @(negedge sys_clk) begin
		uart_byte_t b;
		int         i;
		if (sys_rst_n === 1'b1 && uart_tx_port === START_LEVEL) begin
			repeat (CLKS_PER_BIT/2 - 1) @(negedge sys_clk);
			check_flag(uart_tx_port, START_LEVEL, "monitor start bit");
			for (i = 0; i < DATA_BITS; i++) begin
				repeat (CLKS_PER_BIT) @(negedge sys_clk);
				b[i] = uart_tx_port;
			end
			for (i = 0; i < 2; i++) begin
				repeat (CLKS_PER_BIT) @(negedge sys_clk);
				check_flag(uart_tx_port, LINE_IDLE, $sformatf("monitor stop bit %0d", i));
			end
			mon_q.push_back(b);
		end
	end

	always @(negedge sys_clk) begin
		if (rx_done === 1'b1) begin
			done_cnt++;
		end
		if (rx_error === 1'b1) begin
			err_cnt++;
		end
	end

	initial begin
		case_t    c;
		str_msg_t last_good;
		logic     ok;
		logic     timed_out;
		int       i;
		int       k;
		int       case_err;
		int       ok_cases;
		int       done0;
		int       err0;
		int       mon0;
		int       n_bytes;
		sys_clk      = 1'b0;
		sys_rst_n    = 1'b0;
		tx_msg       = '0;
		tx_req       = 1'b0;
		loopback_sel = 1'b1;
		inj_line     = LINE_IDLE;
		done_cnt     = 0;
		err_cnt      = 0;
		errors       = 0;
		ok_cases     = 0;
		timed_out    = 1'b0;
		last_good    = '0;
		rng_state    = 32'h5057;
		build_table();
		repeat (8) @(negedge sys_clk);
		sys_rst_n = 1'b1;
		@(negedge sys_clk);
		check_flag(tx_busy, 1'b0, "tx_busy after reset");
		check_flag(rx_busy, 1'b0, "rx_busy after reset");
		check_flag(uart_tx_port, LINE_IDLE, "uart_tx_port after reset");
		check_flag(rx_msg == '0, 1'b1, "rx_msg cleared by reset");

		for (i = 0; i < NUM_CASES && !timed_out; i++) begin
			c        = cases[i];
			case_err = errors;
			done0    = done_cnt;
			err0     = err_cnt;
			mon0     = mon_q.size();
			ok       = 1'b1;
			if (c.inject) begin
				loopback_sel = 1'b0;
				inject_frame(c);
			end else begin
				loopback_sel = 1'b1;
				tx_msg = c.msg;
				tx_req = 1'b1;
				@(negedge sys_clk);
				tx_req = 1'b0;
				// A second request in the middle of the frame must be ignored
				repeat (200) @(negedge sys_clk);
				check_flag(tx_busy, 1'b1, "tx_busy during frame");
				check_flag(rx_busy, 1'b1, "rx_busy during frame");
				tx_msg = '1;
				tx_req = 1'b1;
				@(negedge sys_clk);
				tx_req = 1'b0;
				wait_tx_done(ok);
				if (ok) begin
					@(negedge sys_clk);
					check_flag(tx_busy, 1'b0, "tx_busy after tx_done");
				end
			end
			if (ok) begin
				wait_rx_result(done0, err0, ok);
			end
			timed_out = !ok;
			if (ok) begin
				// Leave room for any stray second strobe
				repeat (4*CLKS_PER_BIT) @(negedge sys_clk);
				check_flag(rx_busy, 1'b0, "rx_busy after frame");
				if (!c.inject) begin
					n_bytes = mon_q.size() - mon0;
					if (n_bytes != int'(c.msg.length) + 4) begin
						report_mismatch($sformatf("monitor captured %0d bytes, expected %0d",
							n_bytes, int'(c.msg.length) + 4));
					end else begin
						for (k = 0; k < n_bytes; k++) begin
							check_byte(mon_q[mon0+k], line_byte(c.msg, k),
								$sformatf("tx byte %0d", k));
						end
					end
				end
				if (c.expect_err) begin
					check_flag(err_cnt - err0 == 1, 1'b1, "single rx_error");
					check_flag(done_cnt != done0, 1'b0, "rx_done on overflow");
					check_msg(rx_msg, last_good, "rx_msg kept");
				end else begin
					check_flag(done_cnt - done0 == 1, 1'b1, "single rx_done");
					check_flag(err_cnt != err0, 1'b0, "rx_error on good frame");
					check_msg(rx_msg, c.msg, "rx_msg");
					last_good = c.msg;
				end
			end
			if (ok && errors == case_err) begin
				ok_cases++;
			end
			$display("case %0d %s, %0d chars: %s", i, c.inject ? "inject" : "loopback",
				c.msg.length, !ok ? "timed out" : (errors == case_err) ? "ok" : "errors");
		end

		errors += uart_string_handle_i.uart_string_handle_asserts_i.fail_cnt;
		$display("%0d of %0d cases ok, %0d check errors", ok_cases, NUM_CASES, errors);
		if (errors == 0 && !timed_out) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

//--- testbench/uart_string_handle_asserts.sv
// Protocol assertions for the UART string transceiver top level
// Bound into every instance of the top level
`timescale 1ns/100ps

module uart_string_handle_asserts (
	input logic sys_clk,
	input logic sys_rst_n,
	input logic tx_busy,
	input logic tx_done,
	input logic rx_done,
	input logic rx_error,
	input logic uart_tx_port
);

	int fail_cnt = 0;

	// The transmit line rests high whenever no frame is being sent
	a_tx_idle_line: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		!tx_busy |-> uart_tx_port)
		else begin
			$error("uart_tx_port low while tx_busy is low");
			fail_cnt++;
		end

	a_rx_exclusive: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		!(rx_done && rx_error))
		else begin
			$error("rx_done and rx_error high in the same cycle");
			fail_cnt++;
		end

	a_tx_done_after_busy: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		tx_done |-> $past(tx_busy))
		else begin
			$error("tx_done without tx_busy in the previous cycle");
			fail_cnt++;
		end

endmodule

bind uart_string_handle uart_string_handle_asserts uart_string_handle_asserts_i (
	.sys_clk      (sys_clk),
	.sys_rst_n    (sys_rst_n),
	.tx_busy      (tx_busy),
	.tx_done      (tx_done),
	.rx_done      (rx_done),
	.rx_error     (rx_error),
	.uart_tx_port (uart_tx_port)
);

//--- uart_string_handle.f
hw/uart_pkg.sv
hw/string_pkg.sv
hw/uart_tx.sv
hw/uart_rx.sv
hw/string_framer.sv
hw/string_deframer.sv
hw/uart_string_handle.sv
testbench/uart_string_handle_asserts.sv
testbench/tb_uart_string_handle.sv
